// ==== src/opb_bus_pkg.sv ====
// OPB slave and PSRAM bus widths
package opb_bus_pkg;

    // OPB side.
    localparam int OPB_AW  = 24;
    localparam int OPB_DW  = 32;
    localparam int OPB_BEW = 4;

    // PSRAM side, halfword addressed.
    localparam int PSRAM_AW = 22;
    localparam int PSRAM_DW = 16;

    // Address bit that picks the die.
    localparam int CS_BIT = 23;

endpackage

// ==== src/psram_timing_pkg.sv ====
// PSRAM access timing definitions
package psram_timing_pkg;

    // Sequencer phases.
    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        WR_ADDR    = 4'd1,
        WR_STROBE  = 4'd2,
        WR_SETUP   = 4'd3,
        WR_DATA    = 4'd4,
        WR_RECOVER = 4'd5,
        RD_ADDR    = 4'd6,
        RD_SETUP   = 4'd7,
        RD_WAIT    = 4'd8,
        DONE       = 4'd9
    } psram_phase_t;

    // Write data held with WE low.
    localparam int WR_DATA_CYCLES    = 4;
    // Deselected gap between the two halves of a wide write.
    localparam int WR_RECOVER_CYCLES = 3;
    // Output enable to read data sample.
    localparam int RD_WAIT_CYCLES    = 7;

    localparam int CNT_W = 4;   // Phase counter width.

endpackage

// ==== src/opb_request_sync.sv ====
// OPB request synchronizer
`timescale 1ns/1ps

module opb_request_sync import opb_bus_pkg::*; (
    input  logic               OPB_Clk,
    input  logic               OPB_Rst,
    input  logic               OPB_select,
    input  logic [OPB_AW-1:0]  OPB_ABus,
    input  logic [OPB_DW-1:0]  OPB_DBus,
    input  logic [OPB_BEW-1:0] OPB_BE,
    input  logic               OPB_RNW,
    input  logic               OPB_32Bit,
    input  logic               busy,
    output logic               req,
    output logic [OPB_AW-1:0]  req_addr,
    output logic [OPB_DW-1:0]  req_data,
    output logic [OPB_BEW-1:0] req_be,
    output logic               req_rnw,
    output logic               req_wide
);

    logic sel_q1;
    logic sel_q2;
    logic accept;

    // Rising edge of the synchronized select, dropped while an access runs.
    assign accept = sel_q1 & ~sel_q2 & ~busy;

    always_ff @(posedge OPB_Clk or negedge OPB_Rst) begin
        if (!OPB_Rst) begin
            sel_q1 <= 1'b0;
            sel_q2 <= 1'b0;
            req    <= 1'b0;
        end else begin
            sel_q1 <= OPB_select;   // Sync stage.
            sel_q2 <= sel_q1;       // Edge reference.
            req    <= accept;
        end
    end

    // Stable copies for the rest of the access.
    always_ff @(posedge OPB_Clk) begin
        if (accept) begin
            req_addr <= OPB_ABus;
            req_data <= OPB_DBus;
            req_be   <= OPB_BE;
            req_rnw  <= OPB_RNW;
            req_wide <= OPB_32Bit & ~OPB_RNW;   // Only writes split in two.
        end
    end

endmodule

// ==== src/psram_ctrl.sv ====
// PSRAM access sequencer
`timescale 1ns/1ps

module psram_ctrl import psram_timing_pkg::*; (
    input  logic         OPB_Clk,
    input  logic         OPB_Rst,
    input  logic         req,
    input  logic         req_rnw,
    input  logic         req_wide,
    output psram_phase_t phase,
    output logic         half_hi,
    output logic         busy,
    output logic         sample,
    output logic         finish
);

    logic [CNT_W-1:0] cnt;
    logic             cnt_zero;

    assign cnt_zero = (cnt == '0);

    assign busy   = (phase != IDLE);
    assign sample = (phase == RD_WAIT) && cnt_zero;   // Last wait cycle.
    assign finish = (phase == DONE);

    always_ff @(posedge OPB_Clk or negedge OPB_Rst) begin
        if (!OPB_Rst) begin
            phase   <= IDLE;
            half_hi <= 1'b0;
            cnt     <= '0;
        end else begin
            case (phase)
                IDLE: begin
                    if (req) begin
                        if (req_rnw) begin
                            phase <= RD_ADDR;
                        end else begin
                            phase   <= WR_ADDR;
                            half_hi <= req_wide;   // Wide writes start high.
                        end
                    end
                end

                // Write.
                WR_ADDR: begin
                    phase <= WR_STROBE;
                end
                WR_STROBE: begin
                    phase <= WR_SETUP;
                end
                WR_SETUP: begin
                    phase <= WR_DATA;
                    cnt   <= CNT_W'(WR_DATA_CYCLES - 1);
                end
                WR_DATA: begin
                    if (!cnt_zero) begin
                        cnt <= cnt - 1'b1;
                    end else if (half_hi) begin
                        phase <= WR_RECOVER;
                        cnt   <= CNT_W'(WR_RECOVER_CYCLES - 1);
                    end else begin
                        phase <= DONE;
                    end
                end
                WR_RECOVER: begin
                    if (!cnt_zero) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        // Lower half goes out next.
                        phase   <= WR_ADDR;
                        half_hi <= 1'b0;
                    end
                end

                // Read.
                RD_ADDR: begin
                    phase <= RD_SETUP;
                end
                RD_SETUP: begin
                    phase <= RD_WAIT;
                    cnt   <= CNT_W'(RD_WAIT_CYCLES - 1);
                end
                RD_WAIT: begin
                    if (!cnt_zero) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        phase <= DONE;
                    end
                end

                DONE: begin
                    phase   <= IDLE;
                    half_hi <= 1'b0;
                end

                default: begin
                    phase   <= IDLE;
                    half_hi <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== src/psram_addr_gen.sv ====
// PSRAM address and strobe generator
`timescale 1ns/1ps

module psram_addr_gen import opb_bus_pkg::*, psram_timing_pkg::*; (
    input  logic                OPB_Clk,
    input  logic                OPB_Rst,
    input  psram_phase_t        phase,
    input  logic                half_hi,
    input  logic [OPB_AW-1:0]   req_addr,
    input  logic [OPB_BEW-1:0]  req_be,
    input  logic                req_wide,
    output logic [PSRAM_AW-1:0] PSRAM_Mem_A,
    output logic [1:0]          PSRAM_Mem_BE,
    output logic                PSRAM_Mem_CEN0,
    output logic                PSRAM_Mem_CEN1,
    output logic                PSRAM_Mem_ADV,
    output logic                PSRAM_Mem_WE,
    output logic                PSRAM_Mem_OEN
);

    logic [PSRAM_AW-1:0] hw_addr;
    logic [1:0]          wr_lanes;
    logic                selected;
    logic                addr_phase;

    // Wide writes hit both halfwords of the word, upper first.
    assign hw_addr = req_wide ? {req_addr[PSRAM_AW:2], ~half_hi}
                              : req_addr[PSRAM_AW:1];

    assign wr_lanes   = half_hi ? ~req_be[OPB_BEW-1:2] : ~req_be[1:0];
    assign selected   = (phase != IDLE) && (phase != WR_RECOVER);
    assign addr_phase = (phase == WR_ADDR) || (phase == RD_ADDR);

    always_ff @(posedge OPB_Clk or negedge OPB_Rst) begin
        if (!OPB_Rst) begin
            PSRAM_Mem_CEN0 <= 1'b1;
            PSRAM_Mem_CEN1 <= 1'b1;
            PSRAM_Mem_ADV  <= 1'b1;
            PSRAM_Mem_WE   <= 1'b1;
            PSRAM_Mem_OEN  <= 1'b1;
            PSRAM_Mem_BE   <= 2'b11;
        end else begin
            PSRAM_Mem_CEN0 <= ~(selected & ~req_addr[CS_BIT]);
            PSRAM_Mem_CEN1 <= ~(selected &  req_addr[CS_BIT]);
            PSRAM_Mem_ADV  <= ~addr_phase;
            PSRAM_Mem_WE   <= ~(phase inside {WR_STROBE, WR_SETUP, WR_DATA});
            PSRAM_Mem_OEN  <= (phase != RD_WAIT);

            // Lanes stay put through DONE so they are steady as WE rises.
            case (phase)
                IDLE: PSRAM_Mem_BE <= 2'b11;
                WR_ADDR, WR_STROBE, WR_SETUP, WR_DATA, WR_RECOVER:
                    PSRAM_Mem_BE <= wr_lanes;
                RD_ADDR, RD_SETUP, RD_WAIT:
                    PSRAM_Mem_BE <= 2'b00;   // Full halfword on reads.
                default: ;
            endcase
        end
    end

    always_ff @(posedge OPB_Clk) begin
        if (addr_phase) begin
            PSRAM_Mem_A <= hw_addr;
        end
    end

endmodule

// ==== src/psram_data_path.sv ====
// PSRAM data path
`timescale 1ns/1ps

module psram_data_path import opb_bus_pkg::*, psram_timing_pkg::*; (
    input  logic                OPB_Clk,
    input  logic                OPB_Rst,
    input  psram_phase_t        phase,
    input  logic                half_hi,
    input  logic                sample,
    input  logic                finish,
    input  logic [OPB_AW-1:0]   req_addr,
    input  logic [OPB_DW-1:0]   req_data,
    input  logic [PSRAM_DW-1:0] PSRAM_Mem_DQ_I,
    output logic [PSRAM_DW-1:0] PSRAM_Mem_DQ_O,
    output logic                PSRAM_Mem_DQ_OE,
    output logic [OPB_DW-1:0]   Sln_DBus,
    output logic                Sln_xferAck
);

    logic                lower_pass;   // Second half of a wide write.
    logic                addr_lsb;
    logic [PSRAM_DW-1:0] dq_addr;

    // Upper half at the even halfword, lower half at the odd one.
    assign addr_lsb = half_hi ? 1'b0 : (lower_pass ? 1'b1 : req_addr[1]);
    assign dq_addr  = {req_addr[PSRAM_DW:2], addr_lsb};

    always_ff @(posedge OPB_Clk or negedge OPB_Rst) begin
        if (!OPB_Rst) begin
            lower_pass      <= 1'b0;
            PSRAM_Mem_DQ_OE <= 1'b0;
            Sln_xferAck     <= 1'b0;
        end else begin
            if (phase == WR_RECOVER) begin
                lower_pass <= 1'b1;
            end else if (phase == IDLE) begin
                lower_pass <= 1'b0;
            end
            PSRAM_Mem_DQ_OE <= phase inside {WR_ADDR, WR_STROBE, WR_SETUP, WR_DATA, RD_ADDR};
            Sln_xferAck     <= finish;   // One cycle ack.
        end
    end

    always_ff @(posedge OPB_Clk) begin
        case (phase)
            WR_ADDR, RD_ADDR: PSRAM_Mem_DQ_O <= dq_addr;
            WR_DATA: begin
                PSRAM_Mem_DQ_O <= half_hi ? req_data[OPB_DW-1:PSRAM_DW]
                                          : req_data[PSRAM_DW-1:0];
            end
            default: ;   // Hold, so data is steady at the WE edge.
        endcase

        if (sample) begin
            Sln_DBus <= {2{PSRAM_Mem_DQ_I}};   // Same halfword on both halves.
        end
    end

endmodule

// ==== src/psram_subsystem.sv ====
// OPB to PSRAM bridge
`timescale 1ns/1ps

module psram_subsystem import opb_bus_pkg::*, psram_timing_pkg::*; (
    input  logic [OPB_AW-1:0]   OPB_ABus,
    input  logic [OPB_BEW-1:0]  OPB_BE,
    input  logic                OPB_Clk,
    input  logic [OPB_DW-1:0]   OPB_DBus,
    input  logic                OPB_32Bit,
    input  logic                OPB_RNW,
    input  logic                OPB_Rst,
    input  logic                OPB_select,
    output logic [OPB_DW-1:0]   Sln_DBus,
    output logic                Sln_xferAck,

    input  logic [PSRAM_DW-1:0] PSRAM_Mem_DQ_I,
    output logic [PSRAM_DW-1:0] PSRAM_Mem_DQ_O,
    output logic                PSRAM_Mem_DQ_OE,
    output logic [PSRAM_AW-1:0] PSRAM_Mem_A,
    output logic [1:0]          PSRAM_Mem_BE,
    output logic                PSRAM_Mem_WE,
    output logic                PSRAM_Mem_OEN,
    output logic                PSRAM_Mem_CEN0,
    output logic                PSRAM_Mem_CEN1,
    output logic                PSRAM_Mem_ADV
);

    logic               req;
    logic [OPB_AW-1:0]  req_addr;
    logic [OPB_DW-1:0]  req_data;
    logic [OPB_BEW-1:0] req_be;
    logic               req_rnw;
    logic               req_wide;
    logic               busy;
    psram_phase_t       phase;
    logic               half_hi;
    logic               sample;
    logic               finish;

    opb_request_sync u_req (
        .OPB_Clk    (OPB_Clk),
        .OPB_Rst    (OPB_Rst),
        .OPB_select (OPB_select),
        .OPB_ABus   (OPB_ABus),
        .OPB_DBus   (OPB_DBus),
        .OPB_BE     (OPB_BE),
        .OPB_RNW    (OPB_RNW),
        .OPB_32Bit  (OPB_32Bit),
        .busy       (busy),
        .req        (req),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .req_be     (req_be),
        .req_rnw    (req_rnw),
        .req_wide   (req_wide)
    );

    psram_ctrl u_ctrl (
        .OPB_Clk  (OPB_Clk),
        .OPB_Rst  (OPB_Rst),
        .req      (req),
        .req_rnw  (req_rnw),
        .req_wide (req_wide),
        .phase    (phase),
        .half_hi  (half_hi),
        .busy     (busy),
        .sample   (sample),
        .finish   (finish)
    );

    psram_addr_gen u_addr (
        .OPB_Clk        (OPB_Clk),
        .OPB_Rst        (OPB_Rst),
        .phase          (phase),
        .half_hi        (half_hi),
        .req_addr       (req_addr),
        .req_be         (req_be),
        .req_wide       (req_wide),
        .PSRAM_Mem_A    (PSRAM_Mem_A),
        .PSRAM_Mem_BE   (PSRAM_Mem_BE),
        .PSRAM_Mem_CEN0 (PSRAM_Mem_CEN0),
        .PSRAM_Mem_CEN1 (PSRAM_Mem_CEN1),
        .PSRAM_Mem_ADV  (PSRAM_Mem_ADV),
        .PSRAM_Mem_WE   (PSRAM_Mem_WE),
        .PSRAM_Mem_OEN  (PSRAM_Mem_OEN)
    );

    psram_data_path u_data (
        .OPB_Clk         (OPB_Clk),
        .OPB_Rst         (OPB_Rst),
        .phase           (phase),
        .half_hi         (half_hi),
        .sample          (sample),
        .finish          (finish),
        .req_addr        (req_addr),
        .req_data        (req_data),
        .PSRAM_Mem_DQ_I  (PSRAM_Mem_DQ_I),
        .PSRAM_Mem_DQ_O  (PSRAM_Mem_DQ_O),
        .PSRAM_Mem_DQ_OE (PSRAM_Mem_DQ_OE),
        .Sln_DBus        (Sln_DBus),
        .Sln_xferAck     (Sln_xferAck)
    );

endmodule

// ==== sim/psram_model.sv ====
// PSRAM die model
`timescale 1ns/1ps

module psram_model #(
    parameter logic [3:0] FILL_TAG = 4'h0
) (
    input  logic        ce_n,
    input  logic        adv_n,
    input  logic        we_n,
    input  logic        oe_n,
    input  logic [1:0]  be_n,
    input  logic [15:0] dq_in,
    output logic [15:0] dq_out,
    output logic        dq_drive
);

    logic [15:0] mem [0:4095];
    logic [11:0] addr_q;
    logic        wr_armed = 1'b0;

    // Die tag over the full halfword index.
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i[11:0]] = {FILL_TAG, i[11:0]};
        end
    end

    // Address on DQ is taken as ADV closes.
    always @(posedge adv_n) begin
        if (!ce_n) begin
            addr_q <= dq_in[11:0];
        end
    end

    always @(negedge we_n) begin
        wr_armed <= !ce_n;   // Write cycle opened while selected.
    end

    // Write completes on the rising WE edge, lanes active low.
    always @(posedge we_n) begin
        if (wr_armed) begin
            if (!be_n[1]) begin
                mem[addr_q][15:8] <= dq_in[15:8];
            end
            if (!be_n[0]) begin
                mem[addr_q][7:0] <= dq_in[7:0];
            end
        end
    end

    assign dq_drive = !oe_n && !ce_n;
    assign dq_out   = mem[addr_q];

endmodule

// ==== sim/psram_ctrl_properties.sv ====
// PSRAM sequencer assertions
`timescale 1ns/1ps

module psram_ctrl_properties import psram_timing_pkg::*; (
    input logic         OPB_Clk,
    input logic         OPB_Rst,
    input logic         req,
    input psram_phase_t phase,
    input logic         busy,
    input logic         finish
);

    int unsigned fail_count = 0;   // Read by the testbench at the end.

    // A request only starts from an idle sequencer.
    a_req_idle: assert property (@(posedge OPB_Clk) disable iff (!OPB_Rst)
        req |-> phase == IDLE)
        else begin
            fail_count++;
            $error("req accepted while the sequencer was not idle");
        end

    a_finish_once: assert property (@(posedge OPB_Clk) disable iff (!OPB_Rst)
        finish |=> !finish && phase == IDLE)
        else begin
            fail_count++;
            $error("finish was not a single cycle followed by idle");
        end

    // An accepted request makes the sequencer busy on the next cycle.
    a_busy: assert property (@(posedge OPB_Clk) disable iff (!OPB_Rst)
        req |=> busy)
        else begin
            fail_count++;
            $error("busy did not rise after an accepted request");
        end

endmodule

bind psram_ctrl psram_ctrl_properties u_props (
    .OPB_Clk (OPB_Clk),
    .OPB_Rst (OPB_Rst),
    .req     (req),
    .phase   (phase),
    .busy    (busy),
    .finish  (finish)
);

// ==== sim/tb_psram_subsystem.sv ====
// PSRAM bridge testbench
`timescale 1ns/1ps

module tb_psram_subsystem import opb_bus_pkg::*; ();

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 10;
    localparam int          RAND_OPS     = 32;
    // Directed tests issue 16 requests, a random op at most 3.
    localparam int          NUM_REQUESTS = 16 + 3 * RAND_OPS;
    localparam int          WATCHDOG_CYCLES = 400 * NUM_REQUESTS;
    localparam logic [31:0] RAND_SEED    = 32'h45ac_abaf;
    localparam logic [3:0]  MEM0_TAG     = 4'h3;
    localparam logic [3:0]  MEM1_TAG     = 4'hc;

    logic                OPB_Clk;
    logic                OPB_Rst;
    logic                OPB_select;
    logic [OPB_AW-1:0]   OPB_ABus;
    logic [OPB_DW-1:0]   OPB_DBus;
    logic [OPB_BEW-1:0]  OPB_BE;
    logic                OPB_RNW;
    logic                OPB_32Bit;
    logic [OPB_DW-1:0]   Sln_DBus;
    logic                Sln_xferAck;
    logic [PSRAM_DW-1:0] PSRAM_Mem_DQ_I;
    logic [PSRAM_DW-1:0] PSRAM_Mem_DQ_O;
    logic                PSRAM_Mem_DQ_OE;
    logic [PSRAM_AW-1:0] PSRAM_Mem_A;
    logic [1:0]          PSRAM_Mem_BE;
    logic                PSRAM_Mem_WE;
    logic                PSRAM_Mem_OEN;
    logic                PSRAM_Mem_CEN0;
    logic                PSRAM_Mem_CEN1;
    logic                PSRAM_Mem_ADV;
    logic [15:0]         mem0_dq;
    logic [15:0]         mem1_dq;
    logic                mem0_drive;
    logic                mem1_drive;

    logic [15:0] ref_mem [0:8191];   // Indexed by chip bit and halfword.
    int          errors;

    always #(CLK_PERIOD / 2) OPB_Clk = ~OPB_Clk;

    psram_subsystem dut0 (.*);

    psram_model #(.FILL_TAG(MEM0_TAG)) mem0 (
        .ce_n (PSRAM_Mem_CEN0), .adv_n (PSRAM_Mem_ADV), .we_n (PSRAM_Mem_WE),
        .oe_n (PSRAM_Mem_OEN), .be_n (PSRAM_Mem_BE), .dq_in (PSRAM_Mem_DQ_O),
        .dq_out (mem0_dq), .dq_drive (mem0_drive)
    );

    psram_model #(.FILL_TAG(MEM1_TAG)) mem1 (
        .ce_n (PSRAM_Mem_CEN1), .adv_n (PSRAM_Mem_ADV), .we_n (PSRAM_Mem_WE),
        .oe_n (PSRAM_Mem_OEN), .be_n (PSRAM_Mem_BE), .dq_in (PSRAM_Mem_DQ_O),
        .dq_out (mem1_dq), .dq_drive (mem1_drive)
    );

    assign PSRAM_Mem_DQ_I = mem0_drive ? mem0_dq : (mem1_drive ? mem1_dq : 16'h0000);

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    function automatic logic [12:0] hw_index(input logic [OPB_AW-1:0] addr);
        return {addr[CS_BIT], addr[12:1]};
    endfunction

    function automatic logic [OPB_AW-1:0] random_addr(input logic cs);
        logic [31:0] r;
        r = $urandom();
        return {cs, 10'h000, r[12:2], 2'b00};   // Word aligned.
    endfunction

    task automatic store_half(input logic [12:0] idx, input logic [15:0] data,
                              input logic [1:0] be);
        if (be[1]) ref_mem[idx][15:8] = data[15:8];
        if (be[0]) ref_mem[idx][7:0] = data[7:0];
    endtask

    // One OPB transfer, select held until the acknowledge.
    task automatic bus_access(input logic rnw, input logic wide, input logic [OPB_AW-1:0] addr,
                              input logic [31:0] data, input logic [3:0] be,
                              output logic [31:0] rdata);
        logic [PSRAM_AW-1:0] last_hw;
        @(posedge OPB_Clk);
        #1;
        OPB_ABus   = addr;
        OPB_DBus   = data;
        OPB_BE     = be;
        OPB_RNW    = rnw;
        OPB_32Bit  = wide;
        OPB_select = 1'b1;
        @(negedge OPB_Clk);
        while (!Sln_xferAck) begin
            @(negedge OPB_Clk);
        end
        rdata = Sln_DBus;
        // Address bus holds the last halfword of the access.
        last_hw = wide ? {addr[22:2], 1'b1} : addr[22:1];
        check_value("psram_addr", 32'(last_hw), 32'(PSRAM_Mem_A));
        @(posedge OPB_Clk);
        #1;
        OPB_select = 1'b0;
        repeat (3) @(posedge OPB_Clk);   // Select low must pass the synchronizer.
    endtask

    task automatic write_word(input logic [OPB_AW-1:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        logic [31:0] unused;
        bus_access(1'b0, 1'b1, addr, data, be, unused);
        store_half({addr[CS_BIT], addr[12:2], 1'b0}, data[31:16], be[3:2]);
        store_half({addr[CS_BIT], addr[12:2], 1'b1}, data[15:0], be[1:0]);
    endtask

    // Upper lanes carry junk that the bridge must ignore.
    task automatic write_half(input logic [OPB_AW-1:0] addr, input logic [15:0] data,
                              input logic [1:0] be);
        logic [31:0] unused;
        bus_access(1'b0, 1'b0, addr, {~data, data}, {~be, be}, unused);
        store_half(hw_index(addr), data, be);
    endtask

    task automatic read_check(input string test_name, input logic [OPB_AW-1:0] addr);
        logic [31:0] rdata;
        logic [15:0] expected;
        expected = ref_mem[hw_index(addr)];
        bus_access(1'b1, 1'b0, addr, 32'h0, 4'hf, rdata);
        check_value(test_name, {expected, expected}, rdata);
    endtask

    task automatic test_reset_state();
        check_value("reset_state", 32'h0, 32'(Sln_xferAck));
        check_value("reset_state", 32'h1f, {27'h0, PSRAM_Mem_CEN0, PSRAM_Mem_CEN1,
                    PSRAM_Mem_WE, PSRAM_Mem_OEN, PSRAM_Mem_ADV});
        check_value("reset_state", 32'h3, 32'(PSRAM_Mem_BE));
        check_value("reset_state", 32'h0, 32'(PSRAM_Mem_DQ_OE));
    endtask

    task automatic test_wide_write_read();
        logic [OPB_AW-1:0] addr;
        addr = random_addr(1'b0);
        write_word(addr, $urandom(), 4'hf);
        read_check("wide_write_read", addr);   // Upper data half.
        read_check("wide_write_read", addr + 24'd2);
    endtask

    task automatic test_byte_enables();
        logic [OPB_AW-1:0] addr;
        addr = random_addr(1'b1);
        write_word(addr, $urandom(), 4'hf);
        write_word(addr, $urandom(), 4'b0110);
        write_half(addr + 24'd2, 16'h5a3c, 2'b10);
        read_check("byte_enables", addr);
        read_check("byte_enables", addr + 24'd2);
    endtask

    task automatic test_half_write();
        logic [OPB_AW-1:0] addr;
        logic [31:0]       r;
        addr = random_addr(1'b0);
        r    = $urandom();
        write_word(addr, $urandom(), 4'hf);
        write_half(addr, r[15:0], 2'b11);
        read_check("half_write", addr);
        read_check("half_write", addr + 24'd2);   // Neighbor unchanged.
    endtask

    task automatic test_chip_select();
        logic [OPB_AW-1:0] addr;
        logic [31:0]       r;
        addr = random_addr(1'b0);
        r    = $urandom();
        write_half(addr, r[15:0], 2'b11);
        write_half({1'b1, addr[22:0]}, ~r[15:0], 2'b11);
        read_check("chip_select", addr);
        read_check("chip_select", {1'b1, addr[22:0]});
    endtask

    task automatic test_random();
        logic [OPB_AW-1:0] addr;
        logic [31:0]       r;
        for (int n = 0; n < RAND_OPS; n++) begin
            r    = $urandom();
            addr = random_addr(r[31]);
            if (r[0]) begin
                write_word(addr, $urandom(), r[7:4]);
                read_check("random", addr);
                read_check("random", addr + 24'd2);
            end else begin
                addr[1] = r[1];
                write_half(addr, r[23:8], r[5:4]);
                read_check("random", addr);
            end
        end
    endtask

    initial begin
        int unsigned total;
        void'($urandom(RAND_SEED));
        errors     = 0;
        OPB_Clk    = 1'b0;
        OPB_Rst    = 1'b0;
        OPB_select = 1'b0;
        OPB_ABus   = '0;
        OPB_DBus   = '0;
        OPB_BE     = '0;
        OPB_RNW    = 1'b0;
        OPB_32Bit  = 1'b0;
        for (int i = 0; i < 8192; i++) begin
            ref_mem[i[12:0]] = {i[12] ? MEM1_TAG : MEM0_TAG, i[11:0]};   // Model fill.
        end
        repeat (RESET_CYCLES) @(posedge OPB_Clk);
        #1;
        OPB_Rst = 1'b1;
        @(negedge OPB_Clk);
        test_reset_state();
        test_wide_write_read();
        test_byte_enables();
        test_half_write();
        test_chip_select();
        test_random();
        total = errors + dut0.u_ctrl.u_props.fail_count;
        $display("Errors: %0d check, %0d assertion", errors, dut0.u_ctrl.u_props.fail_count);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge OPB_Clk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
src/opb_bus_pkg.sv
src/psram_timing_pkg.sv
src/opb_request_sync.sv
src/psram_ctrl.sv
src/psram_addr_gen.sv
src/psram_data_path.sv
src/psram_subsystem.sv
sim/psram_model.sv
sim/psram_ctrl_properties.sv
sim/tb_psram_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PSRAM bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_psram_subsystem \
    -o tb_psram_subsystem
./obj_dir/tb_psram_subsystem +verilator+error+limit+1000 | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1
